// File: Makefile
# Verilator build and run of the AIB receive FIFO testbench

VERILATOR = verilator
TOP       = aib_rxfifo_tb
FILELIST  = aib_rxfifo.f
VFLAGS    = --binary --timing --assert -Wno-fatal
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SRCS      = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
PASS_MSG  = Testbench passed

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: aib_rxfifo.f
+incdir+include
rtl/aib_rx_pkg.sv
rtl/aib_rxfifo_cfg.sv
rtl/aib_rxfifo_ctrl.sv
rtl/aib_rxfifo_mem.sv
rtl/aib_rxfifo_rdata_sel.sv
rtl/aib_rxfifo_top.sv
tests/tb_clkgen.sv
tests/aib_rxfifo_tb.sv

// File: include/aib_rx_consts.svh
/* Widths, depth, read-rate codes and register map of the AIB receive FIFO.
   Included by the package and by every RTL file that needs one of them. */

`ifndef AIB_RX_CONSTS_SVH
`define AIB_RX_CONSTS_SVH

// Link word and wide read word
`define AIB_WORD_W       80
`define AIB_DWIDTH       320

// Storage is four rows of four link words
`define AIB_FIFO_DEPTH   4
`define AIB_FIFO_ENTRIES 16
`define AIB_LVL_W        5   // Holds 0 to 16

// Read-rate codes, 2'b11 falls back to full rate
`define AIB_FIFO_1X      2'b00
`define AIB_FIFO_2X      2'b01
`define AIB_FIFO_4X      2'b10

// Register addresses
`define AIB_REG_CTRL     1'b0
`define AIB_REG_LVL      1'b1

`endif

// File: rtl/aib_rx_pkg.sv
/* Shared types of the AIB receive FIFO.
   Imported by wildcard into each module that uses one of them. */

`include "aib_rx_consts.svh"

package aib_rx_pkg;

  // One link word as it arrives from the die-to-die link
  typedef logic [`AIB_WORD_W-1:0]                  fifo_word_t;

  // Wide read word, up to four link words packed low to high
  typedef logic [`AIB_DWIDTH-1:0]                  fifo_rdata_t;

  typedef logic [1:0]                              fifo_mode_t;  // Read-rate code
  typedef logic [`AIB_LVL_W-1:0]                   fifo_lvl_t;   // Fill or start level
  typedef logic [`AIB_FIFO_ENTRIES-1:0]            fifo_sel_t;   // One bit per entry
  typedef logic [$clog2(`AIB_FIFO_ENTRIES)-1:0]    fifo_addr_t;  // Entry index

  typedef logic [7:0]                              cfg_data_t;

  // Read side holds back until the start level is reached
  typedef enum logic [1:0] {
    RD_IDLE = 2'd0,  // FIFO disabled
    RD_FILL = 2'd1,  // Waiting for start level
    RD_RUN  = 2'd2   // Reads allowed
  } rd_state_t;

endpackage

// File: rtl/aib_rxfifo_cfg.sv
/* Configuration registers of the receive FIFO, written by a one-cycle strobe.
   Holds enable, read rate, gen2 select and start level, with combinational readback. */

`timescale 1ns/100ps
`include "aib_rx_consts.svh"

module aib_rxfifo_cfg
  import aib_rx_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cfg_wr,
  input  logic       cfg_addr,
  input  cfg_data_t  cfg_wdata,
  output cfg_data_t  cfg_rdata,
  output logic       fifo_en,
  output fifo_mode_t fifo_mode,
  output logic       gen2_mode,
  output fifo_lvl_t  start_lvl,
  output logic [2:0] grp_size
);

  logic      wr_ctrl;
  logic      wr_lvl;
  fifo_lvl_t lvl_clamped;

  assign wr_ctrl = cfg_wr && (cfg_addr == `AIB_REG_CTRL);
  assign wr_lvl  = cfg_wr && (cfg_addr == `AIB_REG_LVL);

  // Start level cannot exceed the entry count
  assign lvl_clamped = (cfg_wdata[`AIB_LVL_W-1:0] > `AIB_FIFO_ENTRIES) ?
                       fifo_lvl_t'(`AIB_FIFO_ENTRIES) : cfg_wdata[`AIB_LVL_W-1:0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fifo_en   <= 1'b0;
      fifo_mode <= `AIB_FIFO_1X;
      gen2_mode <= 1'b0;
    end
    else if (wr_ctrl)
    begin
      fifo_en   <= cfg_wdata[0];
      fifo_mode <= cfg_wdata[2:1];
      gen2_mode <= cfg_wdata[3];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      start_lvl <= '0;
    else if (wr_lvl)
      start_lvl <= lvl_clamped;
  end

  // Words consumed per read
  always_comb
  begin
    case (fifo_mode)
      `AIB_FIFO_2X: grp_size = 3'd2;
      `AIB_FIFO_4X: grp_size = 3'd4;
      default:      grp_size = 3'd1;  // Also the unused code
    endcase
  end

  always_comb
  begin
    if (cfg_addr == `AIB_REG_LVL)
      cfg_rdata = cfg_data_t'(start_lvl);
    else
      cfg_rdata = {4'b0000, gen2_mode, fifo_mode, fifo_en};
  end

  // Read pointer alignment in the controller relies on a stable group size
  // while the FIFO runs
  a_mode_chg_disabled: assert property (
    @(posedge clk) disable iff (!rst_n)
      (wr_ctrl && (cfg_wdata[2:1] != fifo_mode)) |-> !fifo_en
  );

endmodule

// File: rtl/aib_rxfifo_ctrl.sv
/* Pointer and level control of the receive FIFO. Accepts writes while enabled,
   holds reads back until the start level, and flags overflow and underflow. */

`timescale 1ns/100ps
`include "aib_rx_consts.svh"

module aib_rxfifo_ctrl
  import aib_rx_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       fifo_en,
  input  fifo_lvl_t  start_lvl,
  input  logic [2:0] grp_size,
  input  logic       wr_en,
  input  logic       rd_en,
  output logic       mem_we,
  output fifo_addr_t wr_addr,
  output fifo_sel_t  rd_sel,
  output logic       rdata_valid,
  output logic       fifo_ovf,
  output logic       fifo_udf
);

  rd_state_t  state;
  rd_state_t  state_nxt;
  fifo_addr_t wr_ptr;
  fifo_addr_t rd_ptr;    // Always group aligned
  fifo_lvl_t  lvl;
  fifo_lvl_t  grp_lvl;
  fifo_sel_t  grp_mask;
  logic       full;
  logic       rd_go;
  logic       wr_drop;
  logic       rd_bad;

  assign grp_lvl = fifo_lvl_t'(grp_size);
  assign full    = (lvl == fifo_lvl_t'(`AIB_FIFO_ENTRIES));

  assign rdata_valid = (state == RD_RUN) && (lvl >= grp_lvl);
  assign rd_go       = rd_en && rdata_valid;
  assign rd_bad      = rd_en && (state == RD_RUN) && !rdata_valid;

  // A read in the same cycle frees room for a write at full level
  assign mem_we  = fifo_en && wr_en && (!full || rd_go);
  assign wr_drop = fifo_en && wr_en && full && !rd_go;
  assign wr_addr = wr_ptr;

  // Group of 1, 2 or 4 bits shifted up to the read pointer
  assign grp_mask = (fifo_sel_t'(1) << grp_size) - fifo_sel_t'(1);
  assign rd_sel   = grp_mask << rd_ptr;

  always_comb
  begin
    state_nxt = state;
    if (!fifo_en)
      state_nxt = RD_IDLE;
    else
    begin
      case (state)
        RD_IDLE: state_nxt = RD_FILL;
        RD_FILL: if (lvl >= start_lvl) state_nxt = RD_RUN;
        RD_RUN:  state_nxt = RD_RUN;
        default: state_nxt = RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= RD_IDLE;
    else
      state <= state_nxt;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      lvl    <= '0;
    end
    else if (!fifo_en)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      lvl    <= '0;
    end
    else
    begin
      if (mem_we)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_go)
        rd_ptr <= rd_ptr + fifo_addr_t'(grp_size);  // Wraps at 16
      lvl <= lvl + fifo_lvl_t'(mem_we) - (rd_go ? grp_lvl : '0);
    end
  end

  // Sticky until the FIFO is disabled
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fifo_ovf <= 1'b0;
      fifo_udf <= 1'b0;
    end
    else if (!fifo_en)
    begin
      fifo_ovf <= 1'b0;
      fifo_udf <= 1'b0;
    end
    else
    begin
      if (wr_drop) fifo_ovf <= 1'b1;
      if (rd_bad)  fifo_udf <= 1'b1;
    end
  end

  a_lvl_max: assert property (
    @(posedge clk) disable iff (!rst_n)
      lvl <= fifo_lvl_t'(`AIB_FIFO_ENTRIES)
  );

  // Holds only if the mode never changes while enabled
  a_rd_ptr_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
      (rd_ptr & fifo_addr_t'(grp_size - 3'd1)) == '0
  );

endmodule

// File: rtl/aib_rxfifo_mem.sv
/* Register storage of sixteen link words, written one word per cycle.
   Every entry leaves masked by its select bit for the read-data OR tree. */

`timescale 1ns/100ps
`include "aib_rx_consts.svh"

module aib_rxfifo_mem
  import aib_rx_pkg::*;
(
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               mem_we,
  input  fifo_addr_t                         wr_addr,
  input  fifo_word_t                         wr_data,
  input  fifo_sel_t                          rd_sel,
  output fifo_word_t [`AIB_FIFO_ENTRIES-1:0] fifo_out_sel
);

  // Entry 4r+c is word c of row r
  fifo_word_t [`AIB_FIFO_ENTRIES-1:0] mem_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      mem_q <= '0;
    else if (mem_we)
      mem_q[wr_addr] <= wr_data;
  end

  // Unselected entries read as zero
  always_comb
  begin
    for (int i = 0; i < `AIB_FIFO_ENTRIES; i++)
    begin
      fifo_out_sel[i] = mem_q[i] & {`AIB_WORD_W{rd_sel[i]}};
    end
  end

endmodule

// File: rtl/aib_rxfifo_rdata_sel.sv
/* Builds the 320-bit read word from the masked FIFO entries.
   One OR tree per read rate, picked by mode and link generation. */

`timescale 1ns/100ps
`include "aib_rx_consts.svh"

module aib_rxfifo_rdata_sel
  import aib_rx_pkg::*;
(
  input  fifo_mode_t                         fifo_mode,
  input  logic                               gen2_mode,
  input  fifo_word_t [`AIB_FIFO_ENTRIES-1:0] fifo_out_sel,
  output fifo_rdata_t                        fifo_rdata
);

  fifo_word_t                rdata_1x;
  logic [2*`AIB_WORD_W-1:0]  rdata_2x;
  fifo_word_t                rdata_2x_gen1;  // Two half words
  fifo_rdata_t               rdata_4x;

  // Full rate, a single entry is selected
  always_comb
  begin
    rdata_1x = '0;
    for (int i = 0; i < `AIB_FIFO_ENTRIES; i++)
    begin
      rdata_1x = rdata_1x | fifo_out_sel[i];
    end
  end

  // Half rate gen2, both words in full
  always_comb
  begin
    rdata_2x = '0;
    for (int i = 0; i < 2*`AIB_FIFO_DEPTH; i++)
    begin
      rdata_2x = rdata_2x | {fifo_out_sel[2*i+1], fifo_out_sel[2*i]};
    end
  end

  // Half rate gen1, only the low half of each word carries data
  always_comb
  begin
    rdata_2x_gen1 = '0;
    for (int i = 0; i < 2*`AIB_FIFO_DEPTH; i++)
    begin
      rdata_2x_gen1 = rdata_2x_gen1 |
                      {fifo_out_sel[2*i+1][`AIB_WORD_W/2-1:0],
                       fifo_out_sel[2*i][`AIB_WORD_W/2-1:0]};
    end
  end

  // Quarter rate, one whole row
  always_comb
  begin
    rdata_4x = '0;
    for (int i = 0; i < `AIB_FIFO_DEPTH; i++)
    begin
      rdata_4x = rdata_4x |
                 {fifo_out_sel[4*i+3],
                  fifo_out_sel[4*i+2],
                  fifo_out_sel[4*i+1],
                  fifo_out_sel[4*i]};
    end
  end

  always_comb
  begin
    case (fifo_mode)
      `AIB_FIFO_4X: fifo_rdata = rdata_4x;
      `AIB_FIFO_2X:
      begin
        if (gen2_mode)
          fifo_rdata = fifo_rdata_t'(rdata_2x);
        else
          fifo_rdata = fifo_rdata_t'(rdata_2x_gen1);
      end
      default:      fifo_rdata = fifo_rdata_t'(rdata_1x);  // Upper bits zero
    endcase
  end

endmodule

// File: rtl/aib_rxfifo_top.sv
/* Receive FIFO of the AIB adapter. Link words are written by strobe and read
   one, two or four at a time with zero read latency, under register control. */

`timescale 1ns/100ps
`include "aib_rx_consts.svh"

module aib_rxfifo_top
  import aib_rx_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cfg_wr,
  input  logic        cfg_addr,
  input  cfg_data_t   cfg_wdata,
  input  logic        wr_en,
  input  fifo_word_t  wr_data,
  input  logic        rd_en,
  output cfg_data_t   cfg_rdata,
  output fifo_rdata_t fifo_rdata,
  output logic        rdata_valid,
  output logic        fifo_ovf,
  output logic        fifo_udf
);

  logic                               fifo_en;
  fifo_mode_t                         fifo_mode;
  logic                               gen2_mode;
  fifo_lvl_t                          start_lvl;
  logic [2:0]                         grp_size;   // Words per read
  logic                               mem_we;
  fifo_addr_t                         wr_addr;
  fifo_sel_t                          rd_sel;
  fifo_word_t [`AIB_FIFO_ENTRIES-1:0] fifo_out_sel;

  aib_rxfifo_cfg u_cfg (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .fifo_en   (fifo_en),
    .fifo_mode (fifo_mode),
    .gen2_mode (gen2_mode),
    .start_lvl (start_lvl),
    .grp_size  (grp_size)
  );

  aib_rxfifo_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .fifo_en     (fifo_en),
    .start_lvl   (start_lvl),
    .grp_size    (grp_size),
    .wr_en       (wr_en),
    .rd_en       (rd_en),
    .mem_we      (mem_we),
    .wr_addr     (wr_addr),
    .rd_sel      (rd_sel),
    .rdata_valid (rdata_valid),
    .fifo_ovf    (fifo_ovf),
    .fifo_udf    (fifo_udf)
  );

  aib_rxfifo_mem u_mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_we       (mem_we),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .rd_sel       (rd_sel),
    .fifo_out_sel (fifo_out_sel)
  );

  aib_rxfifo_rdata_sel u_rdata_sel (
    .fifo_mode    (fifo_mode),
    .gen2_mode    (gen2_mode),
    .fifo_out_sel (fifo_out_sel),
    .fifo_rdata   (fifo_rdata)
  );

endmodule

// File: tests/aib_rxfifo_tb.sv
/* Table-driven testbench of the AIB receive FIFO. Each row sets a read rate and start
   level, fills the FIFO and reads it back against a queue model of the written words. */

`timescale 1ns/100ps
`include "aib_rx_consts.svh"

module aib_rxfifo_tb
  import aib_rx_pkg::*;
();

  localparam int N_ROWS      = 8;
  localparam int RST_CYCLES  = 3;
  localparam int CYCLE_LIMIT = 40 * N_ROWS + RST_CYCLES;
  localparam logic [1:0] ERR_NONE = 2'd0;
  localparam logic [1:0] ERR_OVF  = 2'd1;
  localparam logic [1:0] ERR_UDF  = 2'd2;

  typedef struct packed {
    fifo_mode_t mode;
    logic       gen2;
    cfg_data_t  start_raw;  // Before clamping
    logic [5:0] n_wr;
    logic [5:0] n_rd;       // Counted in reads
    logic [1:0] err;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        cfg_wr;
  logic        cfg_addr;
  cfg_data_t   cfg_wdata;
  logic        wr_en;
  fifo_word_t  wr_data;
  logic        rd_en;
  cfg_data_t   cfg_rdata;
  fifo_rdata_t fifo_rdata;
  logic        rdata_valid;
  logic        fifo_ovf;
  logic        fifo_udf;

  row_t        rows [N_ROWS];
  fifo_word_t  model_q [$];   // Stored words with the oldest first
  cfg_data_t   ctrl_reg;      // Last control register value
  integer      seed;
  int          errors;
  int          cycles = 0;

  tb_clkgen u_clk (.clk(clk));

  aib_rxfifo_top dut0 (.*);

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic compare_value(input string name, input logic [`AIB_DWIDTH-1:0] got,
                               input logic [`AIB_DWIDTH-1:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("error at %0d ns: %s expected %0h, got %0h", $time, name, exp, got);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond === 1'b1)
    else
    begin
      errors++;
      $display("Failure at %0d ns: %s", $time, what);
    end
  endtask

  task automatic cfg_write(input logic addr, input cfg_data_t data);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    tick();
    cfg_wr    = 1'b0;
  endtask

  task automatic next_word(output fifo_word_t w);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    w  = {r2[15:0], r1, r0};
  endtask

  function automatic int group_size(input fifo_mode_t mode);
    if (mode == `AIB_FIFO_4X)
      return 4;
    else if (mode == `AIB_FIFO_2X)
      return 2;
    return 1;  // Full rate and the unused code
  endfunction

  function automatic logic [4:0] clamp_lvl(input cfg_data_t raw);
    return (raw[4:0] > 5'd16) ? 5'd16 : raw[4:0];
  endfunction

  // Group packed low to high with unused bits zero
  function automatic fifo_rdata_t build_expected(input fifo_mode_t mode, input logic gen2,
                                                 input fifo_word_t w0, input fifo_word_t w1,
                                                 input fifo_word_t w2, input fifo_word_t w3);
    fifo_rdata_t r;
    r = '0;
    if (mode == `AIB_FIFO_4X)
      r = {w3, w2, w1, w0};
    else if (mode == `AIB_FIFO_2X && gen2)
      r[159:0] = {w1, w0};
    else if (mode == `AIB_FIFO_2X)
      r[79:0] = {w1[39:0], w0[39:0]};  // Gen1 keeps the low half of each word
    else
      r[79:0] = w0;
    return r;
  endfunction

  task automatic load_table();
    rows[0] = '{`AIB_FIFO_4X, 1'b1, 8'd8,  6'd16, 6'd4,  ERR_NONE};
    rows[1] = '{`AIB_FIFO_2X, 1'b1, 8'd4,  6'd20, 6'd10, ERR_NONE};  // Pointers wrap
    rows[2] = '{`AIB_FIFO_1X, 1'b1, 8'd6,  6'd20, 6'd20, ERR_NONE};
    rows[3] = '{`AIB_FIFO_2X, 1'b0, 8'd2,  6'd8,  6'd3,  ERR_NONE};  // Leaves a group stored
    rows[4] = '{2'b11,        1'b0, 8'd0,  6'd3,  6'd3,  ERR_NONE};
    rows[5] = '{`AIB_FIFO_4X, 1'b1, 8'd20, 6'd17, 6'd4,  ERR_OVF};   // Start level clamps
    rows[6] = '{`AIB_FIFO_4X, 1'b0, 8'd4,  6'd6,  6'd2,  ERR_UDF};
    rows[7] = '{`AIB_FIFO_2X, 1'b0, 8'h3f, 6'd16, 6'd8,  ERR_NONE};
  endtask

  task automatic run_row(input int r);
    row_t        row;
    int          grp;
    int          need;
    int          first_wr;
    int          wr_left;
    int          waits;
    logic        wr_now;
    logic [4:0]  lvl;
    fifo_word_t  w;
    fifo_word_t  g [4];
    fifo_rdata_t exp;
    row  = rows[r];
    grp  = group_size(row.mode);
    lvl  = clamp_lvl(row.start_raw);
    need = (int'(lvl) > grp) ? int'(lvl) : grp;

    // Off first and then the new mode and start level
    cfg_write(`AIB_REG_CTRL, {ctrl_reg[7:1], 1'b0});
    ctrl_reg = {4'b0000, row.gen2, row.mode, 1'b0};
    cfg_write(`AIB_REG_CTRL, ctrl_reg);
    cfg_write(`AIB_REG_LVL, row.start_raw);
    compare_value("fifo_ovf", fifo_ovf, 1'b0);
    compare_value("fifo_udf", fifo_udf, 1'b0);
    compare_value("rdata_valid", rdata_valid, 1'b0);
    cfg_addr = `AIB_REG_CTRL;
    #1;
    compare_value("cfg_rdata", cfg_rdata, ctrl_reg);
    cfg_addr = `AIB_REG_LVL;
    #1;
    compare_value("cfg_rdata", cfg_rdata, cfg_data_t'(lvl));
    tick();
    ctrl_reg[0] = 1'b1;
    cfg_write(`AIB_REG_CTRL, ctrl_reg);
    model_q.delete();

    // Fill without reads and stop at 16 unless overflow is tested
    first_wr = (row.err == ERR_OVF || row.n_wr < 6'd16) ? int'(row.n_wr) : 16;
    for (int i = 0; i < first_wr; i++)
    begin
      if (i < need)
        compare_value("rdata_valid", rdata_valid, 1'b0);
      next_word(w);
      wr_en   = 1'b1;
      wr_data = w;
      tick();
      if (model_q.size() < `AIB_FIFO_ENTRIES)
        model_q.push_back(w);  // Dropped at full level
    end
    wr_en = 1'b0;
    if (row.err == ERR_OVF)
      compare_value("fifo_ovf", fifo_ovf, 1'b1);

    wr_left = int'(row.n_wr) - first_wr;
    for (int k = 0; k < int'(row.n_rd); k++)
    begin
      if (model_q.size() >= grp)
      begin
        waits = 0;
        while (!rdata_valid && waits < 4)
        begin
          tick();
          waits++;
        end
        expect_true(rdata_valid, "rdata_valid did not rise with a full group stored");
        for (int j = 0; j < 4; j++)
          g[j] = (j < grp) ? model_q[j] : '0;
        exp = build_expected(row.mode, row.gen2, g[0], g[1], g[2], g[3]);
        compare_value("fifo_rdata", fifo_rdata, exp);
        wr_now = (wr_left > 0);  // Remaining words go in alongside reads
        if (wr_now)
        begin
          next_word(w);
          wr_data = w;
          wr_left--;
        end
        wr_en = wr_now;
        rd_en = 1'b1;
        tick();
        for (int j = 0; j < grp; j++)
          model_q.delete(0);
        if (wr_now)
          model_q.push_back(w);
      end
      else
      begin
        // Too few words for a group
        compare_value("rdata_valid", rdata_valid, 1'b0);
        rd_en = 1'b1;
        tick();
        compare_value("fifo_udf", fifo_udf, 1'b1);
      end
      rd_en = 1'b0;
      wr_en = 1'b0;
    end

    if (model_q.size() < grp)
      compare_value("rdata_valid", rdata_valid, 1'b0);
    else
      compare_value("rdata_valid", rdata_valid, 1'b1);
    if (row.err != ERR_OVF)
      compare_value("fifo_ovf", fifo_ovf, 1'b0);
    if (row.err != ERR_UDF)
      compare_value("fifo_udf", fifo_udf, 1'b0);
  endtask

  initial
  begin
    seed      = 32'h8d1a;
    errors    = 0;
    rst_n     = 1'b0;
    cfg_wr    = 1'b0;
    cfg_addr  = 1'b0;
    cfg_wdata = '0;
    wr_en     = 1'b0;
    wr_data   = '0;
    rd_en     = 1'b0;
    ctrl_reg  = '0;
    load_table();
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int r = 0; r < N_ROWS; r++)
      run_row(r);
    $display("Run complete after %0d cycles, %0d errors", cycles, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: tests/tb_clkgen.sv
/* Free-running testbench clock with a 40 ns period, low at time zero. */

`timescale 1ns/100ps

module tb_clkgen (
  output logic clk
);

  localparam int HALF_PERIOD = 20;  // ns

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule
